// File: source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // datapath widths
  localparam int unsigned XLEN = 32;
  localparam logic [XLEN-1:0] PC_RESET_ADDR = 32'h8000_0000;

  // btb geometry, index from pc[5:2], tag is everything above
  localparam int unsigned BTB_ENTRIES = 16;
  localparam int unsigned BTB_IDX_W   = $clog2(BTB_ENTRIES);
  localparam int unsigned BTB_TAG_W   = XLEN - BTB_IDX_W - 2;

  // fetch queue, depth kept a power of two so the pointers wrap on their own
  localparam int unsigned FQ_DEPTH = 4;
  localparam int unsigned FQ_PTR_W = $clog2(FQ_DEPTH);
  localparam int unsigned FQ_CNT_W = $clog2(FQ_DEPTH + 1);  // needs to hold FQ_DEPTH

  // response latency bound
  localparam int unsigned FETCH_TIMEOUT = 16;
  localparam int unsigned TIMER_W       = $clog2(FETCH_TIMEOUT);
  localparam logic [TIMER_W-1:0] TIMER_MAX = TIMER_W'(FETCH_TIMEOUT - 1);

  typedef enum logic [2:0] {
    S_RESET,  // one idle cycle out of reset
    S_REQ,    // issue the request
    S_WAIT,   // request outstanding
    S_DRAIN,  // outstanding response is stale
    S_FULL,   // queue back-pressure
    S_FAULT   // timed out, parked until a redirect
  } fetch_state_e;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] target;
  } redirect_t;  // trap and branch ports

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;      // branch pc
    logic [XLEN-1:0] target;  // where it goes
  } btb_update_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
  } fetch_entry_t;  // queue slot and decode view

endpackage

`default_nettype wire

// File: source/pc_reg.sv
`timescale 1ns/100ps
`default_nettype none

module pc_reg import fetch_pkg::*; (
  input  wire logic            clk,
  input  wire logic            rst_n_i,
  input  wire logic            stall_i,       // hold the pc
  input  wire logic            pc_adv_i,      // word fetched, step on
  input  wire redirect_t       trap_i,        // from commit / csr
  input  wire redirect_t       branch_i,      // from execute
  input  wire logic            bpu_hit_i,     // btb hit for pc_o
  input  wire logic [XLEN-1:0] bpu_target_i,
  output logic [XLEN-1:0]      pc_o
);

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] pc_next;
  logic            redirect;
  logic            pc_wen;

  assign pc_plus4 = pc_q + 32'd4;
  assign redirect = trap_i.valid | branch_i.valid;

  // fixed priority: trap, branch, prediction, sequential
  always_comb begin
    if (trap_i.valid) begin
      pc_next = trap_i.target;
    end else if (branch_i.valid) begin
      pc_next = branch_i.target;
    end else if (bpu_hit_i) begin
      pc_next = bpu_target_i;  // predicted taken
    end else begin
      pc_next = pc_plus4;
    end
  end

  // redirects get through a stall, the sequential step does not
  assign pc_wen = redirect | (pc_adv_i & ~stall_i);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= PC_RESET_ADDR;
    end else if (pc_wen) begin
      pc_q <= pc_next;
    end
  end

  assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: source/branch_target_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module branch_target_buffer import fetch_pkg::*; (
  input  wire logic            clk,
  input  wire logic            rst_n_i,
  input  wire logic [XLEN-1:0] lookup_pc_i,  // current fetch pc
  input  wire btb_update_t     update_i,     // write strobe from execute
  output logic                 hit_o,
  output logic [XLEN-1:0]      target_o
);

  logic                 valid_q  [BTB_ENTRIES];
  logic [BTB_TAG_W-1:0] tag_q    [BTB_ENTRIES];
  logic [XLEN-1:0]      target_q [BTB_ENTRIES];

  logic [BTB_IDX_W-1:0] lookup_idx;
  logic [BTB_TAG_W-1:0] lookup_tag;
  logic [BTB_IDX_W-1:0] update_idx;
  logic [BTB_TAG_W-1:0] update_tag;

  // word aligned, so bits [1:0] never take part
  assign lookup_idx = lookup_pc_i[BTB_IDX_W+1:2];
  assign lookup_tag = lookup_pc_i[XLEN-1:BTB_IDX_W+2];
  assign update_idx = update_i.pc[BTB_IDX_W+1:2];
  assign update_tag = update_i.pc[XLEN-1:BTB_IDX_W+2];

  // only the valid bits carry state across reset
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (update_i.valid) begin
      valid_q[update_idx] <= 1'b1;
    end
  end

  // tag and target table, overwritten in place
  always_ff @(posedge clk) begin
    if (update_i.valid) begin
      tag_q[update_idx]    <= update_tag;
      target_q[update_idx] <= update_i.target;
    end
  end

  // lookup is purely combinational on the stored table
  assign hit_o    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
  assign target_o = target_q[lookup_idx];  // only meaningful on hit

endmodule

`default_nettype wire

// File: source/fetch_wait_timer.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_wait_timer import fetch_pkg::*; (
  input  wire logic clk,
  input  wire logic rst_n_i,
  input  wire logic clr_i,      // new request going out
  input  wire logic run_i,      // request outstanding
  output logic      expired_o
);

  logic [TIMER_W-1:0] count_q;
  logic               at_max;

  assign at_max = (count_q == TIMER_MAX);

  // saturates at TIMER_MAX, clear wins over run
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (clr_i) begin
      count_q <= '0;
    end else if (run_i && !at_max) begin
      count_q <= count_q + 1'b1;
    end
  end

  // count of 0 is the first wait cycle, so this fires on wait cycle FETCH_TIMEOUT
  assign expired_o = run_i & at_max;

endmodule

`default_nettype wire

// File: source/fetch_queue.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_queue import fetch_pkg::*; #(
  parameter type entry_t = fetch_entry_t
) (
  input  wire logic   clk,
  input  wire logic   rst_n_i,
  input  wire logic   push_i,
  input  wire entry_t push_data_i,
  input  wire logic   pop_i,          // decode strobe
  output entry_t      pop_data_o,     // head entry
  output logic        valid_o,        // not empty
  output logic        full_o,
  output logic        almost_full_o   // one slot left
);

  entry_t              mem_q [FQ_DEPTH];
  logic [FQ_PTR_W-1:0] wr_ptr_q;
  logic [FQ_PTR_W-1:0] rd_ptr_q;
  logic [FQ_CNT_W-1:0] count_q;

  logic do_push;
  logic do_pop;
  logic empty;

  assign empty   = (count_q == '0);
  assign full_o  = (count_q == FQ_CNT_W'(FQ_DEPTH));
  assign do_push = push_i & ~full_o;  // a push into a full queue is lost
  assign do_pop  = pop_i & ~empty;    // pop on empty ignored

  // pointers and occupancy
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at FQ_DEPTH
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      unique case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // both or neither
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  assign pop_data_o    = mem_q[rd_ptr_q];
  assign valid_o       = ~empty;
  assign almost_full_o = (count_q == FQ_CNT_W'(FQ_DEPTH - 1));

endmodule

`default_nettype wire

// File: source/fetch_ctrl_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_ctrl_fsm import fetch_pkg::*; (
  input  wire logic clk,
  input  wire logic rst_n_i,
  input  wire logic imem_rsp_valid_i,
  input  wire logic redirect_i,        // trap or branch
  input  wire logic q_full_i,
  input  wire logic q_almost_full_i,
  input  wire logic timer_expired_i,
  output logic      imem_req_o,
  output logic      push_o,
  output logic      pc_adv_o,
  output logic      stall_o,
  output logic      timer_clr_o,
  output logic      timer_run_o,
  output logic      fault_o            // sticky until redirect
);

  fetch_state_e state_q;
  fetch_state_e state_d;
  fetch_state_e resume;   // where a finished or redirected fetch goes
  logic         rsp_ok;   // usable response this cycle
  logic         fault_q;

  assign resume = q_full_i ? S_FULL : S_REQ;
  assign rsp_ok = (state_q == S_WAIT) & imem_rsp_valid_i & ~redirect_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      S_RESET: state_d = S_REQ;
      S_REQ: begin
        // redirect kills the request before it goes out
        state_d = redirect_i ? resume : S_WAIT;
      end
      S_WAIT: begin
        if (redirect_i) begin
          state_d = imem_rsp_valid_i ? resume : S_DRAIN;  // wrong-path word
        end else if (imem_rsp_valid_i) begin
          state_d = q_almost_full_i ? S_FULL : S_REQ;  // this push takes the last slot
        end else if (timer_expired_i) begin
          state_d = S_FAULT;
        end
      end
      S_DRAIN: begin
        if (imem_rsp_valid_i) begin
          state_d = resume;  // stale word dropped
        end else if (!redirect_i && timer_expired_i) begin
          state_d = S_FAULT;
        end
      end
      S_FULL:  state_d = q_full_i ? S_FULL : S_REQ;
      S_FAULT: state_d = redirect_i ? resume : S_FAULT;  // late responses ignored
      default: state_d = S_RESET;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= S_RESET;
      fault_q <= 1'b0;
    end else begin
      state_q <= state_d;
      fault_q <= (state_d == S_FAULT);  // only a redirect leaves S_FAULT
    end
  end

  assign imem_req_o  = (state_q == S_REQ) & ~redirect_i;
  assign push_o      = rsp_ok;  // S_WAIT is only entered with a free slot
  assign pc_adv_o    = push_o;  // pc steps with every accepted word
  // pc frozen while nothing is being fetched
  assign stall_o     = (state_q == S_RESET) | (state_q == S_DRAIN) |
                       (state_q == S_FULL)  | (state_q == S_FAULT);
  assign timer_clr_o = (state_q == S_REQ);
  assign timer_run_o = (state_q == S_WAIT) | (state_q == S_DRAIN);
  assign fault_o     = fault_q;

endmodule

`default_nettype wire

// File: source/fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
  input  wire logic            clk,
  input  wire logic            rst_n_i,
  input  wire logic            imem_rsp_valid_i,
  input  wire logic [XLEN-1:0] imem_rsp_data_i,
  input  wire redirect_t       trap_i,
  input  wire redirect_t       branch_i,
  input  wire btb_update_t     btb_update_i,
  input  wire logic            dec_pop_i,
  output logic                 imem_req_o,
  output logic [XLEN-1:0]      imem_addr_o,
  output logic                 dec_valid_o,
  output fetch_entry_t         dec_entry_o,
  output logic                 fetch_fault_o
);

  logic [XLEN-1:0] pc;
  logic            pc_adv;
  logic            stall;
  logic            bpu_hit;
  logic [XLEN-1:0] bpu_target;
  logic            push;
  logic            q_full;
  logic            q_almost_full;
  logic            timer_clr;
  logic            timer_run;
  logic            timer_expired;
  logic            redirect;
  fetch_entry_t    push_entry;

  assign redirect    = trap_i.valid | branch_i.valid;
  assign imem_addr_o = pc;  // address held for the whole request
  assign push_entry  = '{pc: pc, inst: imem_rsp_data_i};

  pc_reg u_pc_reg (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .stall_i      (stall),
    .pc_adv_i     (pc_adv),
    .trap_i       (trap_i),
    .branch_i     (branch_i),
    .bpu_hit_i    (bpu_hit),
    .bpu_target_i (bpu_target),
    .pc_o         (pc)
  );

  branch_target_buffer u_btb (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .lookup_pc_i (pc),
    .update_i    (btb_update_i),
    .hit_o       (bpu_hit),
    .target_o    (bpu_target)
  );

  fetch_ctrl_fsm u_ctrl (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .imem_rsp_valid_i (imem_rsp_valid_i),
    .redirect_i       (redirect),
    .q_full_i         (q_full),
    .q_almost_full_i  (q_almost_full),
    .timer_expired_i  (timer_expired),
    .imem_req_o       (imem_req_o),
    .push_o           (push),
    .pc_adv_o         (pc_adv),
    .stall_o          (stall),
    .timer_clr_o      (timer_clr),
    .timer_run_o      (timer_run),
    .fault_o          (fetch_fault_o)
  );

  fetch_wait_timer u_timer (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .clr_i     (timer_clr),
    .run_i     (timer_run),
    .expired_o (timer_expired)
  );

  fetch_queue #(
    .entry_t (fetch_entry_t)
  ) u_queue (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .push_i        (push),
    .push_data_i   (push_entry),
    .pop_i         (dec_pop_i),
    .pop_data_o    (dec_entry_o),
    .valid_o       (dec_valid_o),
    .full_o        (q_full),
    .almost_full_o (q_almost_full)
  );

endmodule

`default_nettype wire

// File: verification/fetch_top_chk.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_top_chk import fetch_pkg::*; (
  input wire logic         clk,
  input wire logic         rst_n_i,
  input wire fetch_state_e state_i,     // fsm state register
  input wire logic         imem_req_i,
  input wire logic         push_i,
  input wire logic         q_full_i,
  input wire logic         q_almost_full_i,
  input wire logic         stall_i,
  input wire logic         pc_adv_i
);

  int unsigned assert_fails = 0;  // read by the testbench top

  // every request that goes out is followed by the wait state
  req_then_wait: assert property (@(posedge clk) disable iff (!rst_n_i)
    imem_req_i |=> (state_i == S_WAIT))
    else begin
      assert_fails++;
      $error("imem request was not followed by the wait state");
    end

  // a push into a full queue would lose the word
  no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n_i)
    push_i |-> !q_full_i)
    else begin
      assert_fails++;
      $error("fetch queue pushed while full");
    end

  // taking the last slot freezes the pc
  hold_after_last_slot: assert property (@(posedge clk) disable iff (!rst_n_i)
    (pc_adv_i && q_almost_full_i) |=> stall_i)
    else begin
      assert_fails++;
      $error("pc not held after the fetch queue filled up");
    end

endmodule

`default_nettype wire

// File: verification/fetch_scoreboard.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_scoreboard import fetch_pkg::*; (
  input  wire logic            clk,
  input  wire logic            rst_n_i,
  input  wire logic [3:0]      test_id_i,
  input  wire logic            req_i,         // dut imem request
  input  wire logic [XLEN-1:0] req_addr_i,    // dut imem address
  input  wire logic            rsp_valid_i,   // memory response
  input  wire redirect_t       trap_i,
  input  wire redirect_t       branch_i,
  input  wire btb_update_t     btb_update_i,
  input  wire logic            dec_pop_i,
  input  wire logic            dec_valid_i,
  input  wire fetch_entry_t    dec_entry_i,
  input  wire logic            fault_i,
  output int                   errors_o,
  output int                   checks_o,
  output int                   pops_o
);

  localparam logic [XLEN-1:0] INST_KEY = 32'h1357_9bdf;  // memory word = addr ^ key

  logic [XLEN-1:0] model_pc;
  logic            btb_valid  [BTB_ENTRIES];
  logic [XLEN-1:0] btb_pc     [BTB_ENTRIES];  // full branch pc for the tag compare on [31:2]
  logic [XLEN-1:0] btb_target [BTB_ENTRIES];
  fetch_entry_t    expect_q [$];               // words the dut must hand to decode
  logic            outstanding;
  logic            stale;                      // redirected while outstanding
  logic            model_fault;
  int unsigned     wait_cycles;

  // trap, then branch, then prediction, then sequential
  function automatic logic [XLEN-1:0] expected_next_pc(input logic [XLEN-1:0] pc,
      input redirect_t trap, input redirect_t branch, input logic btb_hit,
      input logic [XLEN-1:0] btb_tgt);
    if (trap.valid) return trap.target;
    if (branch.valid) return branch.target;
    if (btb_hit) return btb_tgt;
    return pc + 32'd4;
  endfunction

  function automatic string test_name(input logic [3:0] id);
    case (id)
      4'd1:    return "sequential stream";
      4'd2:    return "btb prediction";
      4'd3:    return "stale response drop";
      4'd4:    return "trap over branch";
      4'd5:    return "back-pressure";
      4'd6:    return "fetch timeout";
      default: return "reset";
    endcase
  endfunction

  task automatic report_mismatch(input string what, input logic [63:0] exp,
      input logic [63:0] act);
    errors_o++;
    $display("CHECK FAILED [%s] %s: expected %h, actual %h",
             test_name(test_id_i), what, exp, act);
  endtask

  // sampled mid-cycle when inputs and outputs have settled
  always @(negedge clk or negedge rst_n_i) begin : model
    logic [BTB_IDX_W-1:0] idx;
    logic                 hit;
    logic                 redirect;
    logic                 accept;
    fetch_entry_t         head;
    if (!rst_n_i) begin
      model_pc    = PC_RESET_ADDR;
      outstanding = 1'b0;
      stale       = 1'b0;
      model_fault = 1'b0;
      wait_cycles = 0;
      errors_o    = 0;
      checks_o    = 0;
      pops_o      = 0;
      expect_q.delete();
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        btb_valid[i] = 1'b0;
      end
    end else begin
      idx      = model_pc[BTB_IDX_W+1:2];
      hit      = btb_valid[idx] && (btb_pc[idx][XLEN-1:2] == model_pc[XLEN-1:2]);
      redirect = trap_i.valid | branch_i.valid;
      accept   = 1'b0;
      checks_o += 2;
      if (fault_i !== model_fault) begin
        report_mismatch("fault level", 64'(model_fault), 64'(fault_i));
      end
      if (dec_valid_i !== (expect_q.size() != 0)) begin
        report_mismatch("decode valid", 64'(expect_q.size() != 0), 64'(dec_valid_i));
      end
      if (expect_q.size() > FQ_DEPTH) begin
        errors_o++;
        $display("more responses were taken than the fetch queue can hold");
      end
      if (dec_pop_i && dec_valid_i) begin
        pops_o++;
        if (expect_q.size() == 0) begin
          errors_o++;
          $display("decode popped an entry that was never expected, pc %h", dec_entry_i.pc);
        end else begin
          head = expect_q.pop_front();
          checks_o++;
          if (dec_entry_i !== head) report_mismatch("decode entry", head, dec_entry_i);
        end
      end
      // one request in flight at a time
      if (req_i) begin
        checks_o += 2;
        if (outstanding || model_fault) begin
          errors_o++;
          $display("fetch request issued while another was outstanding or after a fault");
        end
        if (req_addr_i !== model_pc) begin
          report_mismatch("request address", 64'(model_pc), 64'(req_addr_i));
        end
        outstanding = 1'b1;
        stale       = 1'b0;
        wait_cycles = 0;
      end else if (outstanding) begin
        wait_cycles++;
        if (rsp_valid_i) begin
          outstanding = 1'b0;
          accept      = !stale && !redirect;  // same-cycle redirect also kills it
        end else if (wait_cycles >= FETCH_TIMEOUT && !redirect) begin
          outstanding = 1'b0;
          model_fault = 1'b1;
        end else if (redirect) begin
          stale = 1'b1;
        end
      end
      if (accept) begin
        expect_q.push_back(fetch_entry_t'{pc: model_pc, inst: model_pc ^ INST_KEY});
      end
      if (accept || redirect) begin
        model_pc = expected_next_pc(model_pc, trap_i, branch_i, hit, btb_target[idx]);
      end
      if (redirect) model_fault = 1'b0;  // restart clears the fault
      // table write lands after this cycle's lookup
      if (btb_update_i.valid) begin
        btb_valid[btb_update_i.pc[BTB_IDX_W+1:2]]  = 1'b1;
        btb_pc[btb_update_i.pc[BTB_IDX_W+1:2]]     = btb_update_i.pc;
        btb_target[btb_update_i.pc[BTB_IDX_W+1:2]] = btb_update_i.target;
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fetch_top import fetch_pkg::*; ();

  localparam int              CLK_PERIOD   = 4;
  localparam int              RESET_CYCLES = 5;
  localparam int              WAIT_LIMIT   = 200;  // cycles for one wait
  localparam int              NUM_WAITS    = 8;    // waits over all phases
  localparam int              FILL_CYCLES  = 30;   // no-pop phase
  localparam int              WATCHDOG_CYCLES = RESET_CYCLES + NUM_WAITS * WAIT_LIMIT +
                                                FILL_CYCLES + 100;
  localparam logic [XLEN-1:0] BAD_ADDR = 32'h8000_1000;  // memory never answers this
  localparam logic [XLEN-1:0] INST_KEY = 32'h1357_9bdf;

  logic            clk;
  logic            rst_n;
  logic            imem_rsp_valid;
  logic [XLEN-1:0] imem_rsp_data;
  redirect_t       trap;
  redirect_t       branch;
  btb_update_t     btb_update;
  logic            dec_pop;
  logic            imem_req;
  logic [XLEN-1:0] imem_addr;
  logic            dec_valid;
  fetch_entry_t    dec_entry;
  logic            fetch_fault;
  logic [3:0]      test_id;
  logic            pop_en;      // decode allowed to pop
  int              sb_errors;
  int              sb_checks;
  int              sb_pops;
  int              tb_errors;
  int              total_errors;
  integer          seed = 32'h8c8534ab;

  fetch_top u_dut (
    .clk              (clk),
    .rst_n_i          (rst_n),
    .imem_rsp_valid_i (imem_rsp_valid),
    .imem_rsp_data_i  (imem_rsp_data),
    .trap_i           (trap),
    .branch_i         (branch),
    .btb_update_i     (btb_update),
    .dec_pop_i        (dec_pop),
    .imem_req_o       (imem_req),
    .imem_addr_o      (imem_addr),
    .dec_valid_o      (dec_valid),
    .dec_entry_o      (dec_entry),
    .fetch_fault_o    (fetch_fault)
  );

  fetch_scoreboard u_scoreboard (
    .clk          (clk),
    .rst_n_i      (rst_n),
    .test_id_i    (test_id),
    .req_i        (imem_req),
    .req_addr_i   (imem_addr),
    .rsp_valid_i  (imem_rsp_valid),
    .trap_i       (trap),
    .branch_i     (branch),
    .btb_update_i (btb_update),
    .dec_pop_i    (dec_pop),
    .dec_valid_i  (dec_valid),
    .dec_entry_i  (dec_entry),
    .fault_i      (fetch_fault),
    .errors_o     (sb_errors),
    .checks_o     (sb_checks),
    .pops_o       (sb_pops)
  );

  bind fetch_ctrl_fsm fetch_top_chk u_chk (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .state_i         (state_q),
    .imem_req_i      (imem_req_o),
    .push_i          (push_o),
    .q_full_i        (q_full_i),
    .q_almost_full_i (q_almost_full_i),
    .stall_i         (stall_o),
    .pc_adv_i        (pc_adv_o)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // memory answers 1 to 4 cycles after each request and decode pops at random
  initial begin : memory_and_decode
    logic            pend;
    logic            fire;
    logic [XLEN-1:0] addr;
    int              lat;
    pend           = 1'b0;
    fire           = 1'b0;
    addr           = '0;
    lat            = 0;
    imem_rsp_valid = 1'b0;
    imem_rsp_data  = '0;
    dec_pop        = 1'b0;
    forever begin
      @(negedge clk);
      fire = 1'b0;
      if (imem_req && imem_addr != BAD_ADDR) begin
        pend = 1'b1;
        addr = imem_addr;
        lat  = 1 + ($random(seed) & 3);
      end
      if (pend) begin
        lat = lat - 1;
        if (lat == 0) begin
          fire = 1'b1;
          pend = 1'b0;
        end
      end
      @(posedge clk);
      #1;
      imem_rsp_valid = fire;
      imem_rsp_data  = addr ^ INST_KEY;
      dec_pop        = pop_en && (($random(seed) & 1) != 0);
    end
  end

  function automatic redirect_t make_redirect(input logic [XLEN-1:0] target);
    redirect_t r;
    r.valid  = 1'b1;
    r.target = target;
    return r;
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic redirect_pulse(input redirect_t t, input redirect_t b);
    tick();
    trap   = t;
    branch = b;
    tick();
    trap   = '0;
    branch = '0;
  endtask

  task automatic btb_write(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] target);
    tick();
    btb_update = '{valid: 1'b1, pc: pc, target: target};
    tick();
    btb_update = '0;
  endtask

  // scoreboard counts move at negedge and are read here at posedge
  task automatic wait_pops(input int n);
    int target;
    int cycles;
    target = sb_pops + n;
    cycles = 0;
    while (sb_pops < target && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (sb_pops < target) begin
      tb_errors++;
      $display("decode got only %0d of %0d entries in test %0d", n - (target - sb_pops), n,
               test_id);
    end
  endtask

  task automatic wait_request();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!imem_req && cycles < WAIT_LIMIT);
    if (!imem_req) begin
      tb_errors++;
      $display("no fetch request was issued in test %0d", test_id);
    end
  endtask

  task automatic wait_fault();
    int cycles;
    cycles = 0;
    while (!fetch_fault && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!fetch_fault) begin
      tb_errors++;
      $display("fetch fault never rose for the unanswered address");
    end
  endtask

  initial begin : stimulus
    rst_n      = 1'b0;
    trap       = '0;
    branch     = '0;
    btb_update = '0;
    test_id    = 4'd0;
    pop_en     = 1'b0;
    tb_errors  = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;

    test_id = 4'd1;  // straight line from the reset address
    pop_en  = 1'b1;
    wait_pops(12);

    test_id = 4'd2;  // predicted taken branch at 0x100
    btb_write(32'h8000_0100, 32'h8000_0400);
    redirect_pulse('0, make_redirect(32'h8000_0100));
    wait_pops(8);

    test_id = 4'd3;
    wait_request();
    redirect_pulse('0, make_redirect(32'h8000_0800));  // lands while waiting
    wait_pops(8);

    test_id = 4'd4;
    redirect_pulse(make_redirect(32'h8000_0c00), make_redirect(32'h8000_0a00));
    wait_pops(8);

    test_id = 4'd5;  // decode stops, queue fills and fetch stalls
    pop_en  = 1'b0;
    repeat (FILL_CYCLES) tick();
    pop_en = 1'b1;
    wait_pops(10);

    test_id = 4'd6;
    redirect_pulse('0, make_redirect(BAD_ADDR));
    wait_fault();
    redirect_pulse(make_redirect(32'h8000_3000), '0);
    wait_pops(8);
    repeat (10) tick();

    total_errors = sb_errors + tb_errors + int'(u_dut.u_ctrl.u_chk.assert_fails);
    $display("summary: %0d checks, %0d scoreboard errors, %0d testbench errors, %0d %s",
             sb_checks, sb_errors, tb_errors, u_dut.u_ctrl.u_chk.assert_fails,
             "assertion failures");
    if (total_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("run timed out after %0d cycles without finishing all phases", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
source/fetch_pkg.sv
source/pc_reg.sv
source/branch_target_buffer.sv
source/fetch_wait_timer.sv
source/fetch_queue.sv
source/fetch_ctrl_fsm.sv
source/fetch_top.sv
verification/fetch_top_chk.sv
verification/fetch_scoreboard.sv
verification/tb_fetch_top.sv

// File: run.sh
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_fetch_top -f project.f -o sim_fetch_top

./obj_dir/sim_fetch_top +verilator+error+limit+100 | tee "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi
echo "simulation finished without failures"
